// ==== design/usb_diff_pair.sv ====
`timescale 1ns/1ns

module usbDiffPair (
    input  logic clk48,
    input  logic rst,
    inout  logic pinP,
    inout  logic pinN,
    usbLineIf.phy line
);

    logic [1:0] syncP;
    logic [1:0] syncN;

    // ==============================
    // Output drive
    // ==============================

    // Tristate unless transmitting
    assign pinP = line.outEn ? line.dataOutP : 1'bz;
    assign pinN = line.outEn ? line.dataOutN : 1'bz;

    // ==============================
    // Input synchronizers
    // ==============================

    // Two flops per pin, reset to idle J
    always_ff @(posedge clk48) begin
        if (rst) begin
            syncP <= 2'b11;
            syncN <= 2'b00;
        end else begin
            syncP <= {syncP[0], pinP};
            syncN <= {syncN[0], pinN};
        end
    end

    assign line.dataInP = syncP[1];
    assign line.dataInN = syncN[1];

endmodule

// ==== design/usb_event_if.sv ====
`timescale 1ns/1ns

// Packet events from receiver to transmitter
interface usbEventIf import usbPacketPkg::*; ();

    // One-cycle pulse, pid valid alongside
    logic pidStrobe;
    pid_t pid;
    // Level until next SYNC
    logic pidError;
    // One-cycle pulse on J after EOP
    logic packetEnd;
    // Level while long SE0 lasts
    logic busReset;

    modport rx (output pidStrobe, pid, pidError, packetEnd, busReset);
    modport tx (input pidStrobe, pid, pidError, packetEnd, busReset);

endinterface

// ==== design/usb_handshake_tx.sv ====
`timescale 1ns/1ns
`include "usb_config.svh"

module usbHandshakeTx
    import usbLinePkg::*;
    import usbPacketPkg::*;
(
    input  logic clk48,
    input  logic rst,
    usbLineIf.tx line,
    usbEventIf.tx events
);

    localparam int GAP_CYCLES = `USB_TX_GAP_BITS * `USB_SAMPLES_PER_BIT;
    localparam int GAP_WIDTH = $clog2(GAP_CYCLES);
    localparam int ONES_WIDTH = $clog2(`USB_STUFF_LIMIT + 1);
    localparam sampleCount_t SAMPLE_LAST = sampleCount_t'(`USB_SAMPLES_PER_BIT - 1);
    localparam logic [GAP_WIDTH-1:0] GAP_LAST = GAP_WIDTH'(GAP_CYCLES - 1);
    localparam logic [ONES_WIDTH-1:0] STUFF_LIMIT = ONES_WIDTH'(`USB_STUFF_LIMIT);
    localparam pidByte_t SYNC_BYTE = 8'h80;
    localparam pidByte_t ACK_BYTE = {~PID_ACK, PID_ACK};

    logic armed;
    logic gapRun;
    logic dataRun;
    logic eopRun;
    logic allSent;
    logic byteSel;
    logic txLevel;
    logic [GAP_WIDTH-1:0] gapCnt;
    logic [ONES_WIDTH-1:0] onesCnt;
    logic [1:0] eopCnt;
    logic [15:0] txShift;
    sampleCount_t sampleCnt;
    bitCount_t bitCnt;
    logic isDataPid;
    logic bitDone;
    logic gapDone;
    logic stuffNow;
    logic txBit;
    logic newLevel;
    logic emit;

    assign isDataPid = (events.pid == PID_DATA0) || (events.pid == PID_DATA1);
    assign bitDone = (sampleCnt == SAMPLE_LAST);
    assign gapDone = gapRun && (gapCnt == GAP_LAST);

    // Stuffed zero takes the slot without shifting
    assign stuffNow = (onesCnt == STUFF_LIMIT);
    assign txBit = stuffNow ? 1'b0 : txShift[0];
    // NRZI: zero toggles, one holds, txLevel high is J
    assign newLevel = txBit ? txLevel : ~txLevel;
    assign emit = gapDone || (dataRun && bitDone && !(allSent && !stuffNow));

    always_ff @(posedge clk48) begin
        if (rst) begin
            armed     <= 1'b0;
            gapRun    <= 1'b0;
            dataRun   <= 1'b0;
            eopRun    <= 1'b0;
            line.outEn <= 1'b0;
            sampleCnt <= '0;
        end else begin
            sampleCnt <= bitDone ? '0 : sampleCnt + 1'b1;
            // ==============================
            // Arming and turnaround gap
            // ==============================
            if (!dataRun && !eopRun) begin
                if (gapRun) begin
                    gapCnt <= gapCnt + 1'b1;
                    if (gapDone) begin
                        gapRun     <= 1'b0;
                        dataRun    <= 1'b1;
                        line.outEn <= 1'b1;
                        sampleCnt  <= '0;
                    end
                end else if (events.busReset) begin
                    armed <= 1'b0;
                end else if (events.pidStrobe) begin
                    armed <= isDataPid && !events.pidError;
                end else if (events.packetEnd && armed) begin
                    armed   <= 1'b0;
                    gapRun  <= 1'b1;
                    gapCnt  <= '0;
                    txShift <= {ACK_BYTE, SYNC_BYTE};
                    onesCnt <= '0;
                    txLevel <= 1'b1;
                    bitCnt  <= '0;
                    byteSel <= 1'b0;
                    allSent <= 1'b0;
                end
            end else if (dataRun && bitDone && allSent && !stuffNow) begin
                // Last bit done, two bits of SE0
                dataRun       <= 1'b0;
                eopRun        <= 1'b1;
                eopCnt        <= '0;
                line.dataOutP <= 1'b0;
                line.dataOutN <= 1'b0;
            end else if (eopRun && bitDone) begin
                eopCnt <= eopCnt + 1'b1;
                if (eopCnt == 2'd1) begin
                    // One bit of J before release
                    line.dataOutP <= 1'b1;
                    line.dataOutN <= 1'b0;
                end else if (eopCnt == 2'd2) begin
                    eopRun     <= 1'b0;
                    line.outEn <= 1'b0;
                end
            end
            // ==============================
            // Serializer
            // ==============================
            if (emit) begin
                txLevel       <= newLevel;
                line.dataOutP <= newLevel;
                line.dataOutN <= ~newLevel;
                onesCnt       <= txBit ? onesCnt + 1'b1 : '0;
                if (!stuffNow) begin
                    txShift <= txShift >> 1;
                    bitCnt  <= bitCnt + 1'b1;
                    byteSel <= byteSel | (bitCnt == 3'd7);
                    allSent <= byteSel && (bitCnt == 3'd7);
                end
            end
        end
    end

endmodule

// ==== design/usb_line_if.sv ====
`timescale 1ns/1ns

// Synchronized pin samples in, pin drive out
interface usbLineIf ();

    // Input side, after the synchronizers
    logic dataInP;
    logic dataInN;

    // Output side, only on the pins while outEn
    logic outEn;
    logic dataOutP;
    logic dataOutN;

    modport phy (output dataInP, dataInN, input outEn, dataOutP, dataOutN);

    // Receiver also watches outEn to ignore its own echo
    modport rx (input dataInP, dataInN, outEn);

    modport tx (output outEn, dataOutP, dataOutN);

endinterface

// ==== design/usb_line_pkg.sv ====
`include "usb_config.svh"

package usbLinePkg;

    // ==============================
    // Line level types
    // ==============================

    // Encoded as {P, N}
    // J is the idle state of a full-speed bus
    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_K   = 2'b01,
        LINE_J   = 2'b10,
        LINE_SE1 = 2'b11
    } lineState_t;

    // Position within one bit time
    typedef logic [$clog2(`USB_SAMPLES_PER_BIT)-1:0] sampleCount_t;

    // SE0 duration counter for reset detection
    typedef logic [$clog2(`USB_RESET_CYCLES + 1)-1:0] resetCount_t;

endpackage

// ==== design/usb_packet_pkg.sv ====
package usbPacketPkg;

    // ==============================
    // Packet level types
    // ==============================

    // Lower nibble is the PID, upper nibble its inverse
    typedef logic [7:0] pidByte_t;
    typedef logic [3:0] pidNibble_t;

    // PID codes, LSB goes out first
    typedef enum logic [3:0] {
        // Tokens
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SOF   = 4'b0101,
        PID_SETUP = 4'b1101,
        // Data
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        // Handshakes
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } pid_t;

    // Bit index inside a byte
    typedef logic [2:0] bitCount_t;

endpackage

// ==== design/usb_receiver.sv ====
`timescale 1ns/1ns
`include "usb_config.svh"

module usbReceiver
    import usbLinePkg::*;
    import usbPacketPkg::*;
(
    input  logic clk48,
    input  logic rst,
    usbLineIf.rx line,
    usbEventIf.rx events
);

    localparam int ONES_WIDTH = $clog2(`USB_STUFF_LIMIT + 1);
    localparam sampleCount_t SAMPLE_LAST = sampleCount_t'(`USB_SAMPLES_PER_BIT - 1);
    localparam sampleCount_t SAMPLE_MID = sampleCount_t'(`USB_SAMPLES_PER_BIT / 2);
    localparam resetCount_t RESET_LIMIT = resetCount_t'(`USB_RESET_CYCLES);
    localparam logic [ONES_WIDTH-1:0] STUFF_LIMIT = ONES_WIDTH'(`USB_STUFF_LIMIT);
    // Zeros after the leading K of KJKJKJKK
    localparam bitCount_t SYNC_ZEROS = 3'd6;

    typedef enum logic [2:0] {IDLE, SYNC, PID, DATA, EOP} rxState_t;

    rxState_t state;
    lineState_t lineNow;
    lineState_t linePrev;
    lineState_t bitLine;
    sampleCount_t sampleCnt;
    resetCount_t resetCnt;
    bitCount_t bitCnt;
    pidByte_t pidShift;
    pidByte_t pidNext;
    pidNibble_t checkNibble;
    logic [ONES_WIDTH-1:0] onesCnt;
    logic lineIsJK;
    logic bitStrobe;
    logic rxBit;
    logic stuffedBit;

    // ==============================
    // Clock recovery
    // ==============================

    assign lineNow = lineState_t'({line.dataInP, line.dataInN});
    assign lineIsJK = (lineNow == LINE_J) || (lineNow == LINE_K);

    // Mid-bit sample, never on an edge cycle, muted while we transmit
    assign bitStrobe = (sampleCnt == SAMPLE_MID) && (lineNow == linePrev) && !line.outEn;

    // Counter restarts on every line transition
    always_ff @(posedge clk48) begin
        if (rst) begin
            linePrev  <= LINE_J;
            sampleCnt <= '0;
        end else begin
            linePrev <= lineNow;
            if (lineNow != linePrev) begin
                sampleCnt <= sampleCount_t'(1);
            end else if (sampleCnt == SAMPLE_LAST) begin
                sampleCnt <= '0;
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    // ==============================
    // NRZI and unstuffing
    // ==============================

    // No change means one
    assign rxBit = (lineNow == bitLine);
    // Bit after six ones is a stuffed zero
    assign stuffedBit = (onesCnt == STUFF_LIMIT);

    always_ff @(posedge clk48) begin
        if (rst) begin
            bitLine <= LINE_J;
            onesCnt <= '0;
        end else if (bitStrobe) begin
            bitLine <= lineNow;
            if (state == IDLE || !lineIsJK || !rxBit || stuffedBit) begin
                onesCnt <= '0;
            end else begin
                onesCnt <= onesCnt + 1'b1;
            end
        end
    end

    // ==============================
    // Packet framing
    // ==============================

    // PID comes LSB first
    assign pidNext = {rxBit, pidShift[7:1]};
    assign checkNibble = ~pidNext[7:4];

    always_ff @(posedge clk48) begin
        if (rst) begin
            state            <= IDLE;
            bitCnt           <= '0;
            events.pidStrobe <= 1'b0;
            events.pidError  <= 1'b0;
            events.packetEnd <= 1'b0;
        end else begin
            events.pidStrobe <= 1'b0;
            events.packetEnd <= 1'b0;
            if (line.outEn) begin
                state <= IDLE;
            end else if (bitStrobe) begin
                case (state)
                    IDLE: begin
                        // First K opens a SYNC
                        if (lineNow == LINE_K) begin
                            state           <= SYNC;
                            bitCnt          <= '0;
                            events.pidError <= 1'b0;
                        end
                    end
                    SYNC: begin
                        if (!lineIsJK) begin
                            state <= IDLE;
                        end else if (rxBit) begin
                            // Final KK of the pattern
                            state  <= (bitCnt == SYNC_ZEROS) ? PID : IDLE;
                            bitCnt <= '0;
                        end else if (bitCnt == SYNC_ZEROS) begin
                            state <= IDLE;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                    PID: begin
                        if (lineNow == LINE_SE0) begin
                            state <= EOP;
                        end else if (lineNow == LINE_SE1) begin
                            state <= IDLE;
                        end else if (!stuffedBit) begin
                            pidShift <= pidNext;
                            bitCnt   <= bitCnt + 1'b1;
                            if (bitCnt == 3'd7) begin
                                events.pidStrobe <= 1'b1;
                                events.pid       <= pid_t'(pidNext[3:0]);
                                events.pidError  <= (pidNext[3:0] != checkNibble);
                                state            <= DATA;
                            end
                        end
                    end
                    DATA: begin
                        // Payload bits pass unused
                        if (lineNow == LINE_SE0) begin
                            state <= EOP;
                        end else if (lineNow == LINE_SE1) begin
                            state <= IDLE;
                        end
                    end
                    EOP: begin
                        // Packet ends on the J after SE0
                        if (lineNow == LINE_J) begin
                            events.packetEnd <= 1'b1;
                            state            <= IDLE;
                        end else if (lineNow != LINE_SE0) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // ==============================
    // Bus reset detection
    // ==============================

    always_ff @(posedge clk48) begin
        if (rst) begin
            resetCnt        <= '0;
            events.busReset <= 1'b0;
        end else if (lineNow != LINE_SE0) begin
            resetCnt        <= '0;
            events.busReset <= 1'b0;
        end else if (resetCnt == RESET_LIMIT) begin
            events.busReset <= 1'b1;
        end else begin
            resetCnt <= resetCnt + 1'b1;
        end
    end

endmodule

// ==== design/usb_sie.sv ====
`timescale 1ns/1ns

module usbSie (
    input  logic clk48,
    input  logic rst,
    inout  logic usbDp,
    inout  logic usbDn,
    output logic usbPullup,
    output logic busReset
);

    usbLineIf lineBus ();
    usbEventIf eventBus ();

    // ==============================
    // Pins
    // ==============================

    usbDiffPair usbDiffPair_inst (
        .clk48 (clk48),
        .rst   (rst),
        .pinP  (usbDp),
        .pinN  (usbDn),
        .line  (lineBus.phy)
    );

    // ==============================
    // Receive and handshake
    // ==============================

    usbReceiver usbReceiver_inst (
        .clk48  (clk48),
        .rst    (rst),
        .line   (lineBus.rx),
        .events (eventBus.rx)
    );

    usbHandshakeTx usbHandshakeTx_inst (
        .clk48  (clk48),
        .rst    (rst),
        .line   (lineBus.tx),
        .events (eventBus.tx)
    );

    // 1.5k pull-up on D+ marks a full-speed device
    // Held off during reset so the host sees a fresh attach
    always_ff @(posedge clk48) begin
        if (rst) begin
            usbPullup <= 1'b0;
        end else begin
            usbPullup <= 1'b1;
        end
    end

    assign busReset = eventBus.busReset;

endmodule

// ==== dv/usb_host_model.sv ====
`timescale 1ns/1ns
`include "usb_config.svh"

module usbHostModel (
    input  logic clk48,
    inout  wire  dp,
    inout  wire  dn
);

    logic hostEn;
    logic hostP;
    logic hostN;
    // NRZI level, high is J
    logic txLevel;
    int txOnes;

    // Released bus floats to J through the pull resistors
    assign dp = hostEn ? hostP : 1'bz;
    assign dn = hostEn ? hostN : 1'bz;

    initial begin
        hostEn = 1'b0;
        hostP = 1'b1;
        hostN = 1'b0;
        txLevel = 1'b1;
        txOnes = 0;
    end

    // ==============================
    // Transmit side
    // ==============================

    // One line state for a full bit time, entered 2 ns after an edge
    task automatic driveBit(input logic p, input logic n);
        hostEn = 1'b1;
        hostP = p;
        hostN = n;
        repeat (`USB_SAMPLES_PER_BIT) @(posedge clk48);
        #2;
    endtask

    // Zero toggles the line, six ones get a stuffed zero
    task automatic sendBit(input logic value);
        if (!value) begin
            txLevel = ~txLevel;
        end
        driveBit(txLevel, ~txLevel);
        txOnes = value ? txOnes + 1 : 0;
        if (txOnes == `USB_STUFF_LIMIT) begin
            txLevel = ~txLevel;
            driveBit(txLevel, ~txLevel);
            txOnes = 0;
        end
    endtask

    // LSB first
    task automatic sendByte(input logic [7:0] value);
        int i;
        for (i = 0; i < 8; i++) begin
            sendBit(value[i]);
        end
    endtask

    // SYNC, bytes, then SE0 SE0 J
    task automatic sendPacket(input logic [7:0] bytes [$]);
        @(posedge clk48);
        #2;
        txLevel = 1'b1;
        txOnes = 0;
        sendByte(8'h80);
        foreach (bytes[i]) begin
            sendByte(bytes[i]);
        end
        driveBit(1'b0, 1'b0);
        driveBit(1'b0, 1'b0);
        driveBit(1'b1, 1'b0);
        hostEn = 1'b0;
    endtask

    // SE0 stays driven on return
    task automatic holdSe0(input int cycles);
        @(posedge clk48);
        #2;
        hostEn = 1'b1;
        hostP = 1'b0;
        hostN = 1'b0;
        repeat (cycles) @(posedge clk48);
        #2;
    endtask

    // One J bit, then let go of the bus
    task automatic releaseToIdle();
        driveBit(1'b1, 1'b0);
        hostEn = 1'b0;
    endtask

    // ==============================
    // Receive side
    // ==============================

    // Samples on falling edges, away from the DUT's output changes
    task automatic receivePacket(input int maxCycles, output logic [7:0] bytes [$],
                                 output logic timedOut);
        int waited;
        int ones;
        int nBits;
        int samples;
        logic prevLevel;
        logic bitVal;
        logic [7:0] shiftReg;
        bytes = {};
        timedOut = 1'b0;
        waited = 0;
        // First K of SYNC
        @(negedge clk48);
        while (!(dp === 1'b0 && dn === 1'b1)) begin
            if (waited == maxCycles) begin
                timedOut = 1'b1;
                return;
            end
            @(negedge clk48);
            waited++;
        end
        // Step one cycle into the bit
        @(negedge clk48);
        prevLevel = 1'b1;
        ones = 0;
        nBits = 0;
        samples = 0;
        shiftReg = '0;
        while (!(dp === 1'b0 && dn === 1'b0)) begin
            if (samples == 80) begin
                timedOut = 1'b1;
                return;
            end
            bitVal = (dp === prevLevel);
            prevLevel = dp;
            if (ones == `USB_STUFF_LIMIT) begin
                // Stuffed zero, not data
                ones = 0;
            end else begin
                ones = bitVal ? ones + 1 : 0;
                shiftReg = {bitVal, shiftReg[7:1]};
                nBits++;
                if (nBits % 8 == 0) begin
                    bytes.push_back(shiftReg);
                end
            end
            samples++;
            repeat (`USB_SAMPLES_PER_BIT) @(negedge clk48);
        end
        // EOP ends on J
        waited = 0;
        while (!(dp === 1'b1 && dn === 1'b0)) begin
            if (waited == maxCycles) begin
                timedOut = 1'b1;
                return;
            end
            @(negedge clk48);
            waited++;
        end
    endtask

endmodule

// ==== dv/usb_sie_tb.sv ====
`timescale 1ns/1ns

module usbSieTb;

    // 100 bit times at 4 cycles per bit
    localparam int REPLY_CYCLES = 400;

    logic clk48;
    logic rst;
    tri usbDp;
    tri usbDn;
    logic usbPullup;
    logic busReset;

    integer seed;
    int passCount;
    int failCount;
    int testErrors;
    int waitCount;
    logic timedOut;
    logic [7:0] txBytes [$];
    logic [7:0] rxBytes [$];

    // Idle J has D+ high and D- low
    pullup (usbDp);
    pulldown (usbDn);

    usbSie usbSie_inst (
        .clk48     (clk48),
        .rst       (rst),
        .usbDp     (usbDp),
        .usbDn     (usbDn),
        .usbPullup (usbPullup),
        .busReset  (busReset)
    );

    usbHostModel host (
        .clk48 (clk48),
        .dp    (usbDp),
        .dn    (usbDn)
    );

    // Stands in for 48 MHz with a 40 ns period
    always #20 clk48 = ~clk48;

    // ==============================
    // Checking helpers
    // ==============================

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
            testErrors++;
        end
    endtask

    task automatic reportProblem(input string testName, input string what);
        $display("[ERROR] %s: %s", testName, what);
        testErrors++;
    endtask

    // One line per finished test
    task automatic endTest(input string testName);
        if (testErrors == 0) begin
            $display("PASS %s", testName);
            passCount++;
        end else begin
            $display("DONE %s with %0d failed checks", testName, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    // PID byte followed by random payload bytes
    task automatic buildPacket(input logic [7:0] pidByte, input int payloadLen);
        logic [31:0] value;
        txBytes = {};
        txBytes.push_back(pidByte);
        repeat (payloadLen) begin
            value = $random(seed);
            txBytes.push_back(value[7:0]);
        end
    endtask

    // Expect SYNC plus ACK PID followed by idle J
    task automatic expectAck(input string testName);
        host.receivePacket(REPLY_CYCLES, rxBytes, timedOut);
        if (timedOut) begin
            reportProblem(testName, "no complete ACK packet from the DUT within 100 bit times");
        end else begin
            checkValue({testName, " byte count"}, 2, rxBytes.size());
            if (rxBytes.size() == 2) begin
                checkValue({testName, " sync"}, 8'h80, rxBytes[0]);
                checkValue({testName, " pid"}, 8'hD2, rxBytes[1]);
            end
        end
        repeat (8) @(posedge clk48);
        #2;
        checkValue({testName, " idle"}, 2'b10, {usbDp, usbDn});
    endtask

    // Nothing may start within the reply window
    task automatic expectSilence(input string testName);
        host.receivePacket(REPLY_CYCLES, rxBytes, timedOut);
        checkValue({testName, " no reply"}, 1, timedOut);
        // A reply that starts and never ends also times out
        checkValue({testName, " reply bytes"}, 0, rxBytes.size());
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        clk48 = 1'b0;
        rst = 1'b1;
        seed = 32'h0fd4_770d;
        passCount = 0;
        failCount = 0;
        testErrors = 0;
        repeat (3) @(posedge clk48);
        #2;
        rst = 1'b0;
        repeat (4) @(posedge clk48);
        #2;

        checkValue("reset pullup", 1, usbPullup);
        checkValue("reset busReset", 0, busReset);
        checkValue("reset pins", 2'b10, {usbDp, usbDn});
        endTest("reset idle");

        // 0xFF in the payload forces a stuffed bit
        buildPacket(8'hC3, 3);
        txBytes.push_back(8'hFF);
        txBytes.push_back(8'h5A);
        host.sendPacket(txBytes);
        expectAck("data0 ack");
        endTest("data0 ack");

        buildPacket(8'h4B, 4);
        host.sendPacket(txBytes);
        expectAck("data1 ack");
        endTest("data1 ack");

        // Token with only address and endpoint bytes
        buildPacket(8'hE1, 2);
        host.sendPacket(txBytes);
        expectSilence("out token");
        endTest("out token");

        // DATA0 with a broken check nibble
        buildPacket(8'hD3, 3);
        host.sendPacket(txBytes);
        expectSilence("bad pid check");
        endTest("bad pid check");

        host.holdSe0(600);
        checkValue("bus reset level", 1, busReset);
        host.releaseToIdle();
        // busReset follows the line back to J within a few cycles
        waitCount = 0;
        while (busReset !== 1'b0 && waitCount < 50) begin
            @(posedge clk48);
            #2;
            waitCount++;
        end
        checkValue("bus reset release", 0, busReset);
        buildPacket(8'hC3, 2);
        host.sendPacket(txBytes);
        expectAck("bus reset");
        endTest("bus reset");

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== include/usb_config.svh ====
`ifndef USB_CONFIG_SVH
`define USB_CONFIG_SVH

// ==============================
// Full-speed bit timing
// ==============================

// clk48 cycles per 12 Mbit/s bit
`define USB_SAMPLES_PER_BIT 4

// Ones in a row before a zero is stuffed
`define USB_STUFF_LIMIT 6

// SE0 cycles that make a bus reset, 10 us at 48 MHz
`define USB_RESET_CYCLES 480

// Idle bits between host EOP and our handshake
`define USB_TX_GAP_BITS 4

`endif

// ==== run.sh ====
#!/bin/sh
# Build the SIE testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module usbSieTb \
    && ./obj_dir/VusbSieTb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Verilator build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
exit 0

// ==== verilog.f ====
+incdir+include
design/usb_line_pkg.sv
design/usb_packet_pkg.sv
design/usb_line_if.sv
design/usb_event_if.sv
design/usb_diff_pair.sv
design/usb_receiver.sv
design/usb_handshake_tx.sv
design/usb_sie.sv
dv/usb_host_model.sv
dv/usb_sie_tb.sv
